// File: design/conn_consts.svh
`ifndef CONN_CONSTS_SVH
`define CONN_CONSTS_SVH

// Key fields, IPv4 address and UDP port
`define CONN_IP_BITS   32
`define CONN_PORT_BITS 16
`define CONN_KEY_BITS  (`CONN_IP_BITS + `CONN_PORT_BITS)

// Hash folds the key down to a set index
`define CONN_HASH_BITS 4

// Table geometry
`define CONN_WAYS      2
`define CONN_WAY_BITS  1
`define CONN_SETS      16

`endif

// File: design/conn_pkg.sv
`default_nettype none

`include "conn_consts.svh"

package conn_pkg;

  typedef logic [`CONN_HASH_BITS-1:0] conn_idx_t;
  typedef logic [`CONN_WAY_BITS-1:0]  conn_way_t;

  typedef struct packed {
    logic [`CONN_IP_BITS-1:0]   ip;
    logic [`CONN_PORT_BITS-1:0] port;
  } conn_key_t;

  typedef struct packed {
    logic      valid;
    conn_key_t key;
  } conn_entry_t;

  // One table row, all ways of a set
  typedef conn_entry_t [`CONN_WAYS-1:0] conn_set_t;

  typedef struct packed {
    conn_idx_t set;
    conn_way_t way;
  } conn_id_t;

  typedef struct packed {
    logic      wr;
    conn_idx_t set;
    conn_set_t data;
  } table_req_t;

  // Hit doubles as ack for bind and unbind
  typedef struct packed {
    logic      hit;
    logic      full;
    conn_id_t  id;
    conn_key_t key;
  } conn_result_t;

  // XOR of all key nibbles
  function automatic conn_idx_t conn_hash(input conn_key_t key);
    logic [`CONN_KEY_BITS-1:0] flat;
    conn_idx_t                 h;
    flat = key;
    h    = '0;
    for (int i = 0; i < `CONN_KEY_BITS / `CONN_HASH_BITS; i++) begin
      h = h ^ flat[i*`CONN_HASH_BITS +: `CONN_HASH_BITS];
    end
    return h;
  endfunction

endpackage

`default_nettype wire

// File: design/conn_table_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "conn_consts.svh"

module conn_table_mem (
  input  wire                         rx_axis_aclk,
  input  wire                         s_axi_aresetn,
  input  wire                         req_valid,
  input  wire conn_pkg::table_req_t   req,
  output conn_pkg::conn_set_t         rd_data
);
  import conn_pkg::*;

  // Valid bits live apart from the keys so they can be cleared
  logic [`CONN_SETS-1:0][`CONN_WAYS-1:0] valid_q;
  conn_key_t                             key_mem [`CONN_SETS][`CONN_WAYS];

  always_ff @(posedge rx_axis_aclk) begin
    if (!s_axi_aresetn) begin
      valid_q <= '0;
    end else if (req_valid && req.wr) begin
      for (int w = 0; w < `CONN_WAYS; w++) begin
        valid_q[req.set][w] <= req.data[w].valid;
      end
    end
  end

  // Whole-set write or registered read
  always_ff @(posedge rx_axis_aclk) begin
    if (req_valid) begin
      for (int w = 0; w < `CONN_WAYS; w++) begin
        if (req.wr) begin
          key_mem[req.set][w] <= req.data[w].key;
        end else begin
          rd_data[w].valid <= valid_q[req.set][w];
          rd_data[w].key   <= key_mem[req.set][w];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/conn_table_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module conn_table_arbiter (
  input  wire                        rx_axis_aclk,
  input  wire                        s_axi_aresetn,
  input  wire                        ctrl_req,
  input  wire                        fwd_req,
  input  wire                        rev_req,
  input  wire conn_pkg::table_req_t  ctrl_pay,
  input  wire conn_pkg::table_req_t  fwd_pay,
  input  wire conn_pkg::table_req_t  rev_pay,
  output logic                       ctrl_gnt,
  output logic                       fwd_gnt,
  output logic                       rev_gnt,
  output logic                       mem_valid,
  output conn_pkg::table_req_t       mem_req
);

  logic ctrl_ok;
  logic fwd_ok;
  logic rev_ok;

  // A client still shows its request during its grant cycle
  assign ctrl_ok = ctrl_req && !ctrl_gnt;
  assign fwd_ok  = fwd_req && !fwd_gnt;
  assign rev_ok  = rev_req && !rev_gnt;

  // ----------------------------------------
  // Fixed priority, control first
  // ----------------------------------------
  always_ff @(posedge rx_axis_aclk) begin
    if (!s_axi_aresetn) begin
      ctrl_gnt  <= 1'b0;
      fwd_gnt   <= 1'b0;
      rev_gnt   <= 1'b0;
      mem_valid <= 1'b0;
    end else begin
      ctrl_gnt  <= ctrl_ok;
      fwd_gnt   <= fwd_ok && !ctrl_ok;
      rev_gnt   <= rev_ok && !ctrl_ok && !fwd_ok;
      mem_valid <= ctrl_ok || fwd_ok || rev_ok;
    end
  end

  // Payload of the winner goes to the table with the grant
  always_ff @(posedge rx_axis_aclk) begin
    if (ctrl_ok) begin
      mem_req <= ctrl_pay;
    end else if (fwd_ok) begin
      mem_req <= fwd_pay;
    end else if (rev_ok) begin
      mem_req <= rev_pay;
    end
  end

endmodule

`default_nettype wire

// File: design/conn_bind_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "conn_consts.svh"

module conn_bind_ctrl (
  input  wire                        rx_axis_aclk,
  input  wire                        s_axi_aresetn,
  input  wire                        start,
  input  wire                        bind_op,
  input  wire conn_pkg::conn_key_t   key,
  output logic                       tbl_req,
  output conn_pkg::table_req_t       tbl_pay,
  input  wire                        tbl_gnt,
  input  wire conn_pkg::conn_set_t   rd_data,
  output logic                       done,
  output conn_pkg::conn_result_t     result
);
  import conn_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_READ, S_WRITE} state_t;

  state_t       state;
  logic         gnt_d;
  logic         bind_q;
  conn_key_t    key_q;
  logic         hit;
  logic         free;
  logic         need_wr;
  conn_way_t    hit_way;
  conn_way_t    free_way;
  conn_set_t    wr_row;
  conn_result_t res_nx;
  conn_result_t res_q;

  // ----------------------------------------
  // Row decode, lowest way wins
  // ----------------------------------------
  always_comb begin
    hit      = 1'b0;
    free     = 1'b0;
    hit_way  = '0;
    free_way = '0;
    for (int w = `CONN_WAYS - 1; w >= 0; w--) begin
      if (rd_data[w].valid && rd_data[w].key == key_q) begin
        hit     = 1'b1;
        hit_way = conn_way_t'(w);
      end
      if (!rd_data[w].valid) begin
        free     = 1'b1;
        free_way = conn_way_t'(w);
      end
    end
  end

  assign need_wr = bind_q ? (!hit && free) : hit;

  // Modified row, fill a free way or drop the matching one
  always_comb begin
    wr_row = rd_data;
    if (bind_q) begin
      wr_row[free_way].valid = 1'b1;
      wr_row[free_way].key   = key_q;
    end else begin
      wr_row[hit_way].valid = 1'b0;
    end
  end

  always_comb begin
    res_nx.hit    = hit || (bind_q && free);
    res_nx.full   = bind_q && !hit && !free;
    res_nx.id.set = tbl_pay.set;
    res_nx.id.way = (bind_q && !hit) ? free_way : hit_way;
    res_nx.key    = key_q;
  end

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_ff @(posedge rx_axis_aclk) begin
    if (!s_axi_aresetn) begin
      state   <= S_IDLE;
      tbl_req <= 1'b0;
      gnt_d   <= 1'b0;
      done    <= 1'b0;
    end else begin
      done  <= 1'b0;
      gnt_d <= tbl_gnt && (state == S_READ);
      if (tbl_gnt) begin
        tbl_req <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (start) begin
            tbl_req <= 1'b1;
            state   <= S_READ;
          end
        end
        S_READ: begin
          if (gnt_d && need_wr) begin
            tbl_req <= 1'b1;
            state   <= S_WRITE;
          end else if (gnt_d) begin
            done  <= 1'b1;
            state <= S_IDLE;
          end
        end
        S_WRITE: begin
          if (tbl_gnt) begin
            done  <= 1'b1;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Request payload and the result held for the done pulse
  always_ff @(posedge rx_axis_aclk) begin
    if (state == S_IDLE && start) begin
      key_q   <= key;
      bind_q  <= bind_op;
      tbl_pay <= '{wr: 1'b0, set: conn_hash(key), data: '0};
    end
    if (state == S_READ && gnt_d) begin
      tbl_pay.wr   <= 1'b1;
      tbl_pay.data <= wr_row;
      res_q        <= res_nx;
      if (!need_wr) begin
        result <= res_nx;
      end
    end
    if (state == S_WRITE && tbl_gnt) begin
      result <= res_q;
    end
  end

endmodule

`default_nettype wire

// File: design/conn_fwd_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "conn_consts.svh"

module conn_fwd_lookup (
  input  wire                        rx_axis_aclk,
  input  wire                        s_axi_aresetn,
  input  wire                        start,
  input  wire conn_pkg::conn_key_t   key,
  output logic                       tbl_req,
  output conn_pkg::table_req_t       tbl_pay,
  input  wire                        tbl_gnt,
  input  wire conn_pkg::conn_set_t   rd_data,
  output logic                       done,
  output conn_pkg::conn_result_t     result
);
  import conn_pkg::*;

  logic      busy;
  logic      gnt_d;
  logic      hit;
  conn_way_t hit_way;
  conn_key_t key_q;

  // Compare against every valid way
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = `CONN_WAYS - 1; w >= 0; w--) begin
      if (rd_data[w].valid && rd_data[w].key == key_q) begin
        hit     = 1'b1;
        hit_way = conn_way_t'(w);
      end
    end
  end

  always_ff @(posedge rx_axis_aclk) begin
    if (!s_axi_aresetn) begin
      busy    <= 1'b0;
      tbl_req <= 1'b0;
      gnt_d   <= 1'b0;
      done    <= 1'b0;
    end else begin
      done  <= gnt_d;
      gnt_d <= tbl_gnt;
      if (tbl_gnt) begin
        tbl_req <= 1'b0;
      end
      if (!busy && start) begin
        busy    <= 1'b1;
        tbl_req <= 1'b1;
      end else if (gnt_d) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge rx_axis_aclk) begin
    if (!busy && start) begin
      key_q   <= key;
      tbl_pay <= '{wr: 1'b0, set: conn_hash(key), data: '0};
    end
    if (gnt_d) begin
      result <= '{hit: hit, full: 1'b0, id: '{set: tbl_pay.set, way: hit_way}, key: key_q};
    end
  end

endmodule

`default_nettype wire

// File: design/conn_rev_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module conn_rev_lookup (
  input  wire                        rx_axis_aclk,
  input  wire                        s_axi_aresetn,
  input  wire                        start,
  input  wire conn_pkg::conn_id_t    id,
  output logic                       tbl_req,
  output conn_pkg::table_req_t       tbl_pay,
  input  wire                        tbl_gnt,
  input  wire conn_pkg::conn_set_t   rd_data,
  output logic                       done,
  output conn_pkg::conn_result_t     result
);
  import conn_pkg::*;

  logic        busy;
  logic        gnt_d;
  conn_id_t    id_q;
  conn_entry_t entry;

  // Way picked straight from the id
  assign entry = rd_data[id_q.way];

  always_ff @(posedge rx_axis_aclk) begin
    if (!s_axi_aresetn) begin
      busy    <= 1'b0;
      tbl_req <= 1'b0;
      gnt_d   <= 1'b0;
      done    <= 1'b0;
    end else begin
      done  <= gnt_d;
      gnt_d <= tbl_gnt;
      if (tbl_gnt) begin
        tbl_req <= 1'b0;
      end
      if (!busy && start) begin
        busy    <= 1'b1;
        tbl_req <= 1'b1;
      end else if (gnt_d) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge rx_axis_aclk) begin
    if (!busy && start) begin
      id_q    <= id;
      tbl_pay <= '{wr: 1'b0, set: id.set, data: '0};
    end
    if (gnt_d) begin
      result.hit  <= entry.valid;
      result.full <= 1'b0;
      result.id   <= id_q;
      result.key  <= entry.valid ? entry.key : '0;
    end
  end

endmodule

`default_nettype wire

// File: design/conn_manager.sv
`timescale 1ns/1ps
`default_nettype none

module conn_manager (
  input  wire                        rx_axis_aclk,
  input  wire                        s_axi_aresetn,
  // Control client
  input  wire                        ctrl_start,
  input  wire                        ctrl_bind,
  input  wire conn_pkg::conn_key_t   ctrl_key,
  output logic                       ctrl_done,
  output conn_pkg::conn_result_t     ctrl_result,
  // Forward lookup
  input  wire                        fwd_start,
  input  wire conn_pkg::conn_key_t   fwd_key,
  output logic                       fwd_done,
  output conn_pkg::conn_result_t     fwd_result,
  // Reverse lookup
  input  wire                        rev_start,
  input  wire conn_pkg::conn_id_t    rev_id,
  output logic                       rev_done,
  output conn_pkg::conn_result_t     rev_result
);
  import conn_pkg::*;

  logic       ctrl_req, fwd_req, rev_req;
  logic       ctrl_gnt, fwd_gnt, rev_gnt;
  table_req_t ctrl_pay, fwd_pay, rev_pay;
  logic       mem_valid;
  table_req_t mem_req;
  conn_set_t  rd_data;

  // ----------------------------------------
  // Clients
  // ----------------------------------------
  conn_bind_ctrl conn_bind_ctrl_i (
    .rx_axis_aclk (rx_axis_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .start        (ctrl_start),
    .bind_op      (ctrl_bind),
    .key          (ctrl_key),
    .tbl_req      (ctrl_req),
    .tbl_pay      (ctrl_pay),
    .tbl_gnt      (ctrl_gnt),
    .rd_data      (rd_data),
    .done         (ctrl_done),
    .result       (ctrl_result)
  );

  conn_fwd_lookup conn_fwd_lookup_i (
    .rx_axis_aclk (rx_axis_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .start        (fwd_start),
    .key          (fwd_key),
    .tbl_req      (fwd_req),
    .tbl_pay      (fwd_pay),
    .tbl_gnt      (fwd_gnt),
    .rd_data      (rd_data),
    .done         (fwd_done),
    .result       (fwd_result)
  );

  conn_rev_lookup conn_rev_lookup_i (
    .rx_axis_aclk (rx_axis_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .start        (rev_start),
    .id           (rev_id),
    .tbl_req      (rev_req),
    .tbl_pay      (rev_pay),
    .tbl_gnt      (rev_gnt),
    .rd_data      (rd_data),
    .done         (rev_done),
    .result       (rev_result)
  );

  // ----------------------------------------
  // Shared table
  // ----------------------------------------
  conn_table_arbiter conn_table_arbiter_i (
    .rx_axis_aclk (rx_axis_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .ctrl_req     (ctrl_req),
    .fwd_req      (fwd_req),
    .rev_req      (rev_req),
    .ctrl_pay     (ctrl_pay),
    .fwd_pay      (fwd_pay),
    .rev_pay      (rev_pay),
    .ctrl_gnt     (ctrl_gnt),
    .fwd_gnt      (fwd_gnt),
    .rev_gnt      (rev_gnt),
    .mem_valid    (mem_valid),
    .mem_req      (mem_req)
  );

  conn_table_mem conn_table_mem_i (
    .rx_axis_aclk (rx_axis_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .req_valid    (mem_valid),
    .req          (mem_req),
    .rd_data      (rd_data)
  );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset low over the first rising edges
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/conn_checker.sv
`timescale 1ns/1ps
`default_nettype none

module conn_checker (
  input  wire                          clk,
  input  wire                          ctrl_done,
  input  wire conn_pkg::conn_result_t  ctrl_result,
  input  wire conn_pkg::conn_result_t  ctrl_exp,
  input  wire                          ctrl_armed,
  input  wire                          ctrl_id_care,
  input  wire                          fwd_done,
  input  wire conn_pkg::conn_result_t  fwd_result,
  input  wire conn_pkg::conn_result_t  fwd_exp,
  input  wire                          fwd_armed,
  input  wire                          fwd_id_care,
  input  wire                          rev_done,
  input  wire conn_pkg::conn_result_t  rev_result,
  input  wire conn_pkg::conn_result_t  rev_exp,
  input  wire                          rev_armed,
  input  wire                          test_end,
  input  wire [7:0]                    test_num,
  output int                           check_count,
  output int                           error_count
);
  import conn_pkg::*;

  int checks_mark;
  int errors_mark;

  initial begin
    check_count = 0;
    error_count = 0;
    checks_mark = 0;
    errors_mark = 0;
  end

  // One done pulse against the expected result of its client
  task automatic compare(input string who, input logic armed, input logic id_care,
                         input conn_result_t got, input conn_result_t exp);
    if (!armed) begin
      error_count++;
      $display("ERROR at time %0t: %s done pulsed with no request outstanding", $time, who);
    end else begin
      check_count++;
      if (got.hit !== exp.hit || got.full !== exp.full || got.key !== exp.key ||
          (id_care && got.id !== exp.id)) begin
        error_count++;
        $display("MISMATCH at time %0t: %s hit=%0b full=%0b id=%h key=%h, %s",
                 $time, who, got.hit, got.full, got.id, got.key, "expected");
        $display("  expected hit=%0b full=%0b id=%h key=%h",
                 exp.hit, exp.full, exp.id, exp.key);
      end
    end
  endtask

  // ----------------------------------------
  // Sampled on the rising edge
  // ----------------------------------------
  always @(posedge clk) begin
    if (ctrl_done) begin
      compare("control", ctrl_armed, ctrl_id_care, ctrl_result, ctrl_exp);
    end
    if (fwd_done) begin
      compare("forward lookup", fwd_armed, fwd_id_care, fwd_result, fwd_exp);
    end
    if (rev_done) begin
      compare("reverse lookup", rev_armed, 1'b1, rev_result, rev_exp);
    end
    if (test_end) begin
      $display("Test %0d finished: %0d checks, %0d errors", test_num,
               check_count - checks_mark, error_count - errors_mark);
      checks_mark = check_count;
      errors_mark = error_count;
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_conn_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "conn_consts.svh"

module tb_conn_manager;
  import conn_pkg::*;

  localparam int TIMEOUT_CYCLES = 40;
  localparam int NUM_IDS        = `CONN_SETS * `CONN_WAYS;
  localparam int CLIENT_CTRL    = 0;
  localparam int CLIENT_FWD     = 1;
  localparam int CLIENT_REV     = 2;

  logic         clk;
  logic         rst_n;
  logic         ctrl_start;
  logic         ctrl_bind;
  conn_key_t    ctrl_key;
  logic         ctrl_done;
  conn_result_t ctrl_result;
  logic         fwd_start;
  conn_key_t    fwd_key;
  logic         fwd_done;
  conn_result_t fwd_result;
  logic         rev_start;
  conn_id_t     rev_id;
  logic         rev_done;
  conn_result_t rev_result;

  // Expectations handed to the checker
  conn_result_t exp_ctrl;
  conn_result_t exp_fwd;
  conn_result_t exp_rev;
  logic         ctrl_armed;
  logic         fwd_armed;
  logic         rev_armed;
  logic         ctrl_id_care;
  logic         fwd_id_care;
  logic         test_end;
  logic [7:0]   test_num;
  int           check_count;
  int           error_count;

  logic [31:0]  lfsr_state;
  int           issued;
  logic         model_valid [`CONN_SETS][`CONN_WAYS];
  conn_key_t    model_key   [`CONN_SETS][`CONN_WAYS];

  tb_clock_gen clock_gen_i (
    .clk  (clk),
    .rst_n(rst_n)
  );

  conn_manager conn_manager_i (
    .rx_axis_aclk (clk),
    .s_axi_aresetn(rst_n),
    .ctrl_start   (ctrl_start),
    .ctrl_bind    (ctrl_bind),
    .ctrl_key     (ctrl_key),
    .ctrl_done    (ctrl_done),
    .ctrl_result  (ctrl_result),
    .fwd_start    (fwd_start),
    .fwd_key      (fwd_key),
    .fwd_done     (fwd_done),
    .fwd_result   (fwd_result),
    .rev_start    (rev_start),
    .rev_id       (rev_id),
    .rev_done     (rev_done),
    .rev_result   (rev_result)
  );

  conn_checker checker_i (
    .clk         (clk),
    .ctrl_done   (ctrl_done),
    .ctrl_result (ctrl_result),
    .ctrl_exp    (exp_ctrl),
    .ctrl_armed  (ctrl_armed),
    .ctrl_id_care(ctrl_id_care),
    .fwd_done    (fwd_done),
    .fwd_result  (fwd_result),
    .fwd_exp     (exp_fwd),
    .fwd_armed   (fwd_armed),
    .fwd_id_care (fwd_id_care),
    .rev_done    (rev_done),
    .rev_result  (rev_result),
    .rev_exp     (exp_rev),
    .rev_armed   (rev_armed),
    .test_end    (test_end),
    .test_num    (test_num),
    .check_count (check_count),
    .error_count (error_count)
  );

  // ----------------------------------------
  // Random source
  // ----------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Small key pool over fixed upper bits so sets collide often
  function automatic conn_key_t pool_key();
    conn_key_t   k;
    logic [31:0] r;
    r      = rand_bits(3);
    k.ip   = 32'hC0A80100 | r;
    r      = rand_bits(2);
    k.port = 16'h1F90 | r[15:0];
    return k;
  endfunction

  // Set index is the XOR of the twelve key nibbles
  function automatic conn_idx_t key_hash(input conn_key_t k);
    logic [47:0] bits;
    conn_idx_t   h;
    bits = {k.ip, k.port};
    h    = '0;
    repeat (12) begin
      h    = h ^ bits[3:0];
      bits = bits >> 4;
    end
    return h;
  endfunction

  // ----------------------------------------
  // Reference table model
  // ----------------------------------------
  task automatic model_ctrl(input logic is_bind, input conn_key_t k, output conn_result_t r);
    conn_idx_t s;
    int        hit_w;
    int        free_w;
    s      = key_hash(k);
    hit_w  = -1;
    free_w = -1;
    for (int w = 0; w < `CONN_WAYS; w++) begin
      if (hit_w < 0 && model_valid[s][w] && model_key[s][w] == k) hit_w = w;
      if (free_w < 0 && !model_valid[s][w]) free_w = w;
    end
    r        = '0;
    r.key    = k;
    r.id.set = s;
    if (is_bind && hit_w >= 0) begin
      r.hit    = 1'b1;
      r.id.way = conn_way_t'(hit_w);
    end else if (is_bind && free_w >= 0) begin
      r.hit                 = 1'b1;
      r.id.way              = conn_way_t'(free_w);
      model_valid[s][free_w] = 1'b1;
      model_key[s][free_w]   = k;
    end else if (is_bind) begin
      r.full = 1'b1;
    end else if (hit_w >= 0) begin
      r.hit                 = 1'b1;
      r.id.way              = conn_way_t'(hit_w);
      model_valid[s][hit_w] = 1'b0;
    end
  endtask

  task automatic model_fwd(input conn_key_t k, output conn_result_t r);
    conn_idx_t s;
    s        = key_hash(k);
    r        = '0;
    r.key    = k;
    r.id.set = s;
    for (int w = 0; w < `CONN_WAYS; w++) begin
      if (!r.hit && model_valid[s][w] && model_key[s][w] == k) begin
        r.hit    = 1'b1;
        r.id.way = conn_way_t'(w);
      end
    end
  endtask

  task automatic model_rev(input conn_id_t id, output conn_result_t r);
    r     = '0;
    r.id  = id;
    r.hit = model_valid[id.set][id.way];
    if (r.hit) r.key = model_key[id.set][id.way];
  endtask

  // ----------------------------------------
  // Request drivers
  // ----------------------------------------
  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  endtask

  function automatic logic done_of(input int client);
    case (client)
      CLIENT_CTRL: return ctrl_done;
      CLIENT_FWD:  return fwd_done;
      default:     return rev_done;
    endcase
  endfunction

  task automatic wait_done(input int client, input string what);
    int cycles;
    cycles = 0;
    while (!done_of(client)) begin
      if (cycles == TIMEOUT_CYCLES) report_timeout({what, " done pulse"});
      @(posedge clk);
      cycles++;
    end
    case (client)
      CLIENT_CTRL: ctrl_armed <= 1'b0;
      CLIENT_FWD:  fwd_armed  <= 1'b0;
      default:     rev_armed  <= 1'b0;
    endcase
    issued++;
  endtask

  task automatic run_ctrl(input logic is_bind, input conn_key_t k);
    conn_result_t r;
    model_ctrl(is_bind, k, r);
    @(posedge clk);
    exp_ctrl     <= r;
    ctrl_id_care <= r.hit;
    ctrl_armed   <= 1'b1;
    ctrl_start   <= 1'b1;
    ctrl_bind    <= is_bind;
    ctrl_key     <= k;
    @(posedge clk);
    ctrl_start <= 1'b0;
    wait_done(CLIENT_CTRL, "control");
  endtask

  // Unbind every key the model holds in one set
  task automatic clear_set(input conn_idx_t s);
    for (int w = 0; w < `CONN_WAYS; w++) begin
      if (model_valid[s][w]) begin
        run_ctrl(1'b0, model_key[s][w]);
      end
    end
  endtask

  task automatic run_fwd(input conn_key_t k);
    conn_result_t r;
    model_fwd(k, r);
    @(posedge clk);
    exp_fwd     <= r;
    fwd_id_care <= r.hit;
    fwd_armed   <= 1'b1;
    fwd_start   <= 1'b1;
    fwd_key     <= k;
    @(posedge clk);
    fwd_start <= 1'b0;
    wait_done(CLIENT_FWD, "forward lookup");
  endtask

  task automatic run_rev(input conn_id_t id);
    conn_result_t r;
    model_rev(id, r);
    @(posedge clk);
    exp_rev   <= r;
    rev_armed <= 1'b1;
    rev_start <= 1'b1;
    rev_id    <= id;
    @(posedge clk);
    rev_start <= 1'b0;
    wait_done(CLIENT_REV, "reverse lookup");
  endtask

  // All three clients start together
  // Control request here never writes
  task automatic run_mixed(input logic is_bind, input conn_key_t ck,
                           input conn_key_t fk, input conn_id_t rid);
    conn_result_t rc;
    conn_result_t rf;
    conn_result_t rr;
    logic         seen_c;
    logic         seen_f;
    logic         seen_r;
    int           cycles;
    model_fwd(fk, rf);
    model_rev(rid, rr);
    model_ctrl(is_bind, ck, rc);
    @(posedge clk);
    exp_ctrl     <= rc;
    exp_fwd      <= rf;
    exp_rev      <= rr;
    ctrl_id_care <= rc.hit;
    fwd_id_care  <= rf.hit;
    ctrl_armed   <= 1'b1;
    fwd_armed    <= 1'b1;
    rev_armed    <= 1'b1;
    ctrl_start   <= 1'b1;
    ctrl_bind    <= is_bind;
    ctrl_key     <= ck;
    fwd_start    <= 1'b1;
    fwd_key      <= fk;
    rev_start    <= 1'b1;
    rev_id       <= rid;
    @(posedge clk);
    ctrl_start <= 1'b0;
    fwd_start  <= 1'b0;
    rev_start  <= 1'b0;
    seen_c = 1'b0;
    seen_f = 1'b0;
    seen_r = 1'b0;
    cycles = 0;
    while (!(seen_c && seen_f && seen_r)) begin
      if (cycles == TIMEOUT_CYCLES) report_timeout("all concurrent done pulses");
      @(posedge clk);
      cycles++;
      if (ctrl_done && !seen_c) begin
        seen_c = 1'b1;
        ctrl_armed <= 1'b0;
      end
      if (fwd_done && !seen_f) begin
        seen_f = 1'b1;
        fwd_armed <= 1'b0;
      end
      if (rev_done && !seen_r) begin
        seen_r = 1'b1;
        rev_armed <= 1'b0;
      end
    end
    issued += 3;
  endtask

  task automatic end_test(input int num);
    @(posedge clk);
    test_num <= 8'(num);
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int          cycles;
    logic [31:0] r;
    logic [4:0]  idv;
    conn_key_t   k;
    conn_key_t   k1;
    conn_key_t   k2;
    conn_key_t   k3;
    conn_id_t    rid;

    lfsr_state = 32'd89839;
    issued     = 0;
    for (int i = 0; i < `CONN_SETS; i++) begin
      for (int w = 0; w < `CONN_WAYS; w++) begin
        model_valid[i][w] = 1'b0;
        model_key[i][w]   = '0;
      end
    end
    ctrl_start   <= 1'b0;
    ctrl_bind    <= 1'b0;
    ctrl_key     <= '0;
    fwd_start    <= 1'b0;
    fwd_key      <= '0;
    rev_start    <= 1'b0;
    rev_id       <= '0;
    exp_ctrl     <= '0;
    exp_fwd      <= '0;
    exp_rev      <= '0;
    ctrl_armed   <= 1'b0;
    fwd_armed    <= 1'b0;
    rev_armed    <= 1'b0;
    ctrl_id_care <= 1'b0;
    fwd_id_care  <= 1'b0;
    test_end     <= 1'b0;
    test_num     <= 8'd0;

    cycles = 0;
    while (rst_n !== 1'b1) begin
      if (cycles == TIMEOUT_CYCLES) report_timeout("reset release");
      @(posedge clk);
      cycles++;
    end
    repeat (3) @(posedge clk);

    // Every lookup misses on the empty table
    for (int i = 0; i < 16; i++) run_fwd(pool_key());
    end_test(1);

    // Random binds and unbinds
    for (int i = 0; i < 64; i++) begin
      r = rand_bits(2);
      run_ctrl(r[1:0] != 2'b00, pool_key());
    end
    // One key bound twice into an emptied set
    k = pool_key();
    clear_set(key_hash(k));
    run_ctrl(1'b1, k);
    run_ctrl(1'b1, k);
    end_test(2);

    // Third of three keys on one set finds it full
    r        = rand_bits(16);
    k1.ip    = {16'h0A00, r[15:0]};
    r        = rand_bits(8);
    k1.port  = {8'h30, r[7:0]};
    k2       = k1;
    k2.ip    = k1.ip ^ 32'h00001100;
    k3       = k1;
    k3.ip    = k1.ip ^ 32'h00002200;
    clear_set(key_hash(k1));
    run_ctrl(1'b1, k1);
    run_ctrl(1'b1, k2);
    run_ctrl(1'b1, k3);
    end_test(3);

    for (int i = 0; i < 40; i++) run_fwd(pool_key());
    run_fwd(k2);
    run_fwd(k3);
    end_test(4);

    for (int i = 0; i < NUM_IDS; i++) begin
      idv = i[4:0];
      rid = idv;
      run_rev(rid);
    end
    end_test(5);

    // Bind of a present key and unbind of an absent key leave the table alone
    for (int i = 0; i < 12; i++) begin
      r   = rand_bits(5);
      rid = r[4:0];
      run_mixed(i % 2 == 0, (i % 2 == 0) ? k1 : k3, pool_key(), rid);
    end
    end_test(6);

    repeat (2) @(posedge clk);
    $display("Summary: 6 tests, %0d requests, %0d checks, %0d errors",
             issued, check_count, error_count);
    if (error_count == 0 && check_count == issued) begin
      $display("Simulation passed");
    end else begin
      if (check_count != issued) begin
        $display("Only %0d of %0d requests were checked", check_count, issued);
      end
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/conn_pkg.sv
design/conn_table_mem.sv
design/conn_table_arbiter.sv
design/conn_bind_ctrl.sv
design/conn_fwd_lookup.sv
design/conn_rev_lookup.sv
design/conn_manager.sv
bench/tb_clock_gen.sv
bench/conn_checker.sv
bench/tb_conn_manager.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_conn_manager
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
